// File: Bender.yml
package:
  name: stack_core

sources:
  - source/core_cfg_pkg.sv
  - source/core_isa_pkg.sv
  - source/core_alu.sv
  - source/data_stack.sv
  - source/call_stack.sv
  - source/instruction_decoder.sv
  - source/pc_control.sv
  - source/stack_core.sv
  - target: simulation
    files:
      - verif/stack_core_sva.sv
      - verif/tb_stack_core.sv

// File: project.f
source/core_cfg_pkg.sv
source/core_isa_pkg.sv
source/core_alu.sv
source/data_stack.sv
source/call_stack.sv
source/instruction_decoder.sv
source/pc_control.sv
source/stack_core.sv
verif/stack_core_sva.sv
verif/tb_stack_core.sv

// File: source/call_stack.sv
`timescale 1ns/1ps

module call_stack
  import core_cfg_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       hold,
  input  logic       push,
  input  logic       pop,
  input  prog_addr_t ret_addr_in,
  output prog_addr_t ret_addr,
  output logic       overflow,
  output logic       underflow
);

  prog_addr_t  stk [call_depth];
  call_count_t count;

  assign ret_addr = stk[call_idx_t'(count - call_count_t'(1))];

  assign overflow  = push && (count == call_count_t'(call_depth));
  assign underflow = pop && (count == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (!hold) begin
      if (push) begin
        count <= count + call_count_t'(1);
      end else if (pop) begin
        count <= count - call_count_t'(1);
      end
    end
  end

  // Return addresses are written at the slot just above the current top
  always_ff @(posedge clk) begin
    if (!hold && push) begin
      stk[call_idx_t'(count)] <= ret_addr_in;
    end
  end

endmodule

// File: source/core_alu.sv
`timescale 1ns/1ps

module core_alu
  import core_cfg_pkg::*;
  import core_isa_pkg::*;
(
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  // Operand a is the second stack word and b is the top, so sub gives second minus top
  always_comb begin
    case (op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_and: begin
        result = a & b;
      end
      alu_or: begin
        result = a | b;
      end
      alu_xor: begin
        result = a ^ b;
      end
      default: begin
        result = b;
      end
    endcase
  end

endmodule

// File: source/core_cfg_pkg.sv
package core_cfg_pkg;

  // Machine widths
  localparam int word_w      = 16;
  localparam int prog_addr_w = 8;
  localparam int main_addr_w = 8;

  // Stack capacities
  localparam int data_depth = 8;
  localparam int call_depth = 4;

  // Index and fill count widths
  // The count needs one more state than the index
  localparam int data_idx_w   = $clog2(data_depth);
  localparam int data_count_w = $clog2(data_depth + 1);
  localparam int call_idx_w   = $clog2(call_depth);
  localparam int call_count_w = $clog2(call_depth + 1);

  typedef logic [word_w-1:0]       word_t;
  typedef logic [prog_addr_w-1:0]  prog_addr_t;
  typedef logic [main_addr_w-1:0]  main_addr_t;
  typedef logic [data_idx_w-1:0]   data_idx_t;
  typedef logic [data_count_w-1:0] data_count_t;
  typedef logic [call_idx_w-1:0]   call_idx_t;
  typedef logic [call_count_w-1:0] call_count_t;

endpackage

// File: source/core_isa_pkg.sv
package core_isa_pkg;

  // An instruction byte is either a 7-bit immediate (top bit set) or an opcode
  typedef logic [7:0] instr_t;
  typedef logic [6:0] imm_t;

  localparam int imm_flag_bit = 7;

  typedef enum logic [4:0] {
    op_nop   = 5'd0,
    op_add   = 5'd1,
    op_sub   = 5'd2,
    op_and   = 5'd3,
    op_or    = 5'd4,
    op_xor   = 5'd5,
    op_dup   = 5'd6,
    op_drop  = 5'd7,
    op_swap  = 5'd8,
    op_jmp   = 5'd9,
    op_jz    = 5'd10,
    op_call  = 5'd11,
    op_ret   = 5'd12,
    op_load  = 5'd13,
    op_store = 5'd14,
    op_halt  = 5'd15
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_pass
  } alu_op_e;

  typedef enum logic [1:0] {
    move_hold,
    move_push,
    move_pop,
    move_pop2
  } stack_move_e;

  typedef enum logic [1:0] {
    pc_advance,
    pc_top,
    pc_return,
    pc_hold
  } next_pc_e;

  // Source of the word written into the top slot of the data stack
  typedef enum logic [2:0] {
    src_alu,
    src_imm,
    src_mem,
    src_second,
    src_top
  } top_src_e;

  typedef struct packed {
    alu_op_e     alu_op;
    stack_move_e stack_move;
    top_src_e    top_src;
    logic        swap;
    next_pc_e    pc_src;
    logic        branch_on_zero;
    logic        call_push;
    logic        call_pop;
    logic        mem_read;
    logic        mem_write;
    logic        halt_req;
  } ctrl_t;

endpackage

// File: source/data_stack.sv
`timescale 1ns/1ps

module data_stack
  import core_cfg_pkg::*;
  import core_isa_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        hold,
  input  stack_move_e move,
  input  logic        swap,
  input  word_t       new_top,
  output word_t       top,
  output word_t       second,
  output logic        overflow,
  output logic        underflow
);

  word_t       stk [data_depth];
  data_count_t count;
  data_idx_t   top_idx;
  data_idx_t   second_idx;
  data_idx_t   push_idx;

  // Entry 0 is the bottom, the top sits at count - 1
  assign top_idx    = data_idx_t'(count - data_count_t'(1));
  assign second_idx = data_idx_t'(count - data_count_t'(2));
  assign push_idx   = data_idx_t'(count);

  assign top    = stk[top_idx];
  assign second = stk[second_idx];

  assign overflow = (move == move_push) && (count == data_count_t'(data_depth));

  always_comb begin
    case (move)
      move_pop: begin
        underflow = (count == '0);
      end
      move_pop2: begin
        underflow = (count < data_count_t'(2));
      end
      move_hold: begin
        // A swap needs two words even though the count does not change
        underflow = swap && (count < data_count_t'(2));
      end
      default: begin
        underflow = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (!hold) begin
      case (move)
        move_push: count <= count + data_count_t'(1);
        move_pop:  count <= count - data_count_t'(1);
        move_pop2: count <= count - data_count_t'(2);
        default:   count <= count;
      endcase
    end
  end

  // After a pop the new top is the old second slot, which takes new_top
  always_ff @(posedge clk) begin
    if (!hold) begin
      case (move)
        move_push: begin
          stk[push_idx] <= new_top;
        end
        move_pop: begin
          if (count >= data_count_t'(2)) begin
            stk[second_idx] <= new_top;
          end
        end
        move_hold: begin
          if (swap) begin
            stk[second_idx] <= top;
            stk[top_idx]    <= new_top;
          end else if (count != '0) begin
            stk[top_idx] <= new_top;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// File: source/instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder
  import core_isa_pkg::*;
(
  input  instr_t instr,
  output ctrl_t  ctrl
);

  opcode_e op;

  assign op = opcode_e'(instr[4:0]);

  always_comb begin
    // Defaults describe a nop, every field below only departs from it
    ctrl                = '0;
    ctrl.alu_op         = alu_pass;
    ctrl.stack_move     = move_hold;
    ctrl.top_src        = src_top;
    ctrl.pc_src         = pc_advance;

    if (instr[imm_flag_bit]) begin
      ctrl.stack_move = move_push;
      ctrl.top_src    = src_imm;
    end else begin
      case (op)
        op_add, op_sub, op_and, op_or, op_xor: begin
          ctrl.stack_move = move_pop;
          ctrl.top_src    = src_alu;
          case (op)
            op_add:  ctrl.alu_op = alu_add;
            op_sub:  ctrl.alu_op = alu_sub;
            op_and:  ctrl.alu_op = alu_and;
            op_or:   ctrl.alu_op = alu_or;
            default: ctrl.alu_op = alu_xor;
          endcase
        end
        op_dup: begin
          ctrl.stack_move = move_push;
        end
        op_drop: begin
          ctrl.stack_move = move_pop;
          ctrl.top_src    = src_second;
        end
        op_swap: begin
          ctrl.swap    = 1'b1;
          ctrl.top_src = src_second;
        end
        op_jmp, op_call: begin
          ctrl.stack_move = move_pop;
          ctrl.top_src    = src_second;
          ctrl.pc_src     = pc_top;
          ctrl.call_push  = (op == op_call);
        end
        op_jz: begin
          // Target on top and condition below it, both consumed
          ctrl.stack_move     = move_pop2;
          ctrl.pc_src         = pc_top;
          ctrl.branch_on_zero = 1'b1;
        end
        op_ret: begin
          ctrl.pc_src   = pc_return;
          ctrl.call_pop = 1'b1;
        end
        op_load: begin
          ctrl.top_src  = src_mem;
          ctrl.mem_read = 1'b1;
        end
        op_store: begin
          ctrl.stack_move = move_pop2;
          ctrl.mem_write  = 1'b1;
        end
        op_halt: begin
          ctrl.pc_src   = pc_hold;
          ctrl.halt_req = 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// File: source/pc_control.sv
`timescale 1ns/1ps

module pc_control
  import core_cfg_pkg::*;
  import core_isa_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  ctrl_t      ctrl,
  input  word_t      top,
  input  word_t      second,
  input  prog_addr_t ret_addr,
  input  logic       stack_fault,
  output prog_addr_t prog_addr,
  output prog_addr_t link_addr,
  output logic       hold,
  output logic       halted,
  output logic       fault
);

  // Address of the instruction executing this cycle
  prog_addr_t pc;
  prog_addr_t pc_seq;
  prog_addr_t pc_target;
  prog_addr_t pc_d;
  logic       stall_q;
  logic       load_wait;
  logic       branch_taken;
  logic       freeze;

  assign pc_seq    = pc + prog_addr_t'(1);
  assign link_addr = pc_seq;

  // First cycle of a load waits for main memory, the second one completes it
  assign load_wait = ctrl.mem_read && !stall_q;

  // A stack fault freezes the core already in the cycle that causes it
  assign freeze = fault || halted || stack_fault;
  assign hold   = freeze || load_wait;

  assign branch_taken = !ctrl.branch_on_zero || (second == '0);

  always_comb begin
    case (ctrl.pc_src)
      pc_top: begin
        pc_target = branch_taken ? prog_addr_t'(top) : pc_seq;
      end
      pc_return: begin
        pc_target = ret_addr;
      end
      pc_hold: begin
        pc_target = pc;
      end
      default: begin
        pc_target = pc_seq;
      end
    endcase
  end

  // The program memory sees the next address so that it returns the byte one edge later
  always_comb begin
    if (rst) begin
      pc_d = '0;
    end else if (hold) begin
      pc_d = pc;
    end else begin
      pc_d = pc_target;
    end
  end

  assign prog_addr = pc_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= '0;
      stall_q <= 1'b0;
      halted  <= 1'b0;
      fault   <= 1'b0;
    end else begin
      pc      <= pc_d;
      stall_q <= load_wait && !freeze;
      if (ctrl.halt_req && !freeze) begin
        halted <= 1'b1;
      end
      if (stack_fault) begin
        fault <= 1'b1;
      end
    end
  end

endmodule

// File: source/stack_core.sv
`timescale 1ns/1ps

module stack_core
  import core_cfg_pkg::*;
  import core_isa_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  output prog_addr_t prog_addr,
  input  instr_t     prog_data,
  output main_addr_t mem_raddr,
  output main_addr_t mem_addr,
  input  word_t      mem_rdata,
  output word_t      mem_wdata,
  output logic       mem_we,
  output logic       halted,
  output logic       fault
);

  ctrl_t      ctrl;
  word_t      top;
  word_t      second;
  word_t      alu_result;
  word_t      new_top;
  imm_t       imm;
  prog_addr_t ret_addr;
  prog_addr_t link_addr;
  logic       hold;
  logic       ds_overflow;
  logic       ds_underflow;
  logic       cs_overflow;
  logic       cs_underflow;
  logic       stack_fault;

  instruction_decoder u_decoder (
    .instr (prog_data),
    .ctrl  (ctrl)
  );

  core_alu u_alu (
    .op     (ctrl.alu_op),
    .a      (second),
    .b      (top),
    .result (alu_result)
  );

  assign imm = imm_t'(prog_data[6:0]);

  always_comb begin
    case (ctrl.top_src)
      src_alu:    new_top = alu_result;
      src_imm:    new_top = word_t'(imm);
      src_mem:    new_top = mem_rdata;
      src_second: new_top = second;
      default:    new_top = top;
    endcase
  end

  data_stack u_data_stack (
    .clk       (clk),
    .rst       (rst),
    .hold      (hold),
    .move      (ctrl.stack_move),
    .swap      (ctrl.swap),
    .new_top   (new_top),
    .top       (top),
    .second    (second),
    .overflow  (ds_overflow),
    .underflow (ds_underflow)
  );

  call_stack u_call_stack (
    .clk         (clk),
    .rst         (rst),
    .hold        (hold),
    .push        (ctrl.call_push),
    .pop         (ctrl.call_pop),
    .ret_addr_in (link_addr),
    .ret_addr    (ret_addr),
    .overflow    (cs_overflow),
    .underflow   (cs_underflow)
  );

  assign stack_fault = ds_overflow || ds_underflow || cs_overflow || cs_underflow;

  pc_control u_pc_control (
    .clk         (clk),
    .rst         (rst),
    .ctrl        (ctrl),
    .top         (top),
    .second      (second),
    .ret_addr    (ret_addr),
    .stack_fault (stack_fault),
    .prog_addr   (prog_addr),
    .link_addr   (link_addr),
    .hold        (hold),
    .halted      (halted),
    .fault       (fault)
  );

  // Loads and stores both take their address from the top of the stack
  assign mem_raddr = main_addr_t'(top);
  assign mem_addr  = main_addr_t'(top);
  assign mem_wdata = second;
  assign mem_we    = ctrl.mem_write && !hold;

endmodule

// File: verif/stack_core_sva.sv
`timescale 1ns/1ps

module stack_core_sva
  import core_cfg_pkg::*;
  import core_isa_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input prog_addr_t prog_addr,
  input instr_t     prog_data,
  input main_addr_t mem_addr,
  input word_t      mem_wdata,
  input logic       mem_we,
  input logic       halted,
  input logic       fault,
  input word_t      top,
  input logic       hold
);

  localparam word_t      arg_a      = 16'd9;
  localparam word_t      arg_b      = 16'd5;
  localparam word_t      load_value = 16'd37;
  localparam main_addr_t trap_addr  = 8'd255;
  localparam int         n_slots    = 12;

  int                 fail_count = 0;
  logic [n_slots-1:0] stores_seen;
  logic               is_load;

  assign is_load = (prog_data == instr_t'(op_load));

  // Slot of a checked result address, or -1 for addresses the program never checks
  function automatic int check_slot(main_addr_t a);
    case (a)
      8'd1, 8'd2, 8'd3, 8'd4, 8'd5, 8'd6, 8'd7, 8'd8, 8'd9, 8'd10: begin
        return int'(a) - 1;
      end
      8'd20:   return 10;
      8'd21:   return 11;
      default: return -1;
    endcase
  endfunction

  function automatic word_t expected_word(main_addr_t a);
    case (a)
      8'd1:    return arg_a + arg_b;
      8'd2:    return arg_a - arg_b;
      8'd3:    return arg_a & arg_b;
      8'd4:    return arg_a | arg_b;
      8'd5:    return arg_a ^ arg_b;
      // Swap lifts the first pushed 3 to the top, then dup doubles the 7 left below
      8'd6:    return word_t'(3);
      8'd7:    return word_t'(7 + 7);
      // Markers of the control flow section
      8'd8:    return word_t'(1);
      8'd9:    return word_t'(2);
      8'd10:   return word_t'(3);
      8'd20:   return load_value;
      8'd21:   return load_value + word_t'(1);
      default: return '0;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      stores_seen <= '0;
    end else if (mem_we && check_slot(mem_addr) >= 0) begin
      stores_seen[check_slot(mem_addr)] <= 1'b1;
    end
  end

  // Registered outputs are only defined once the first reset edge has passed
  reset_values: assert property (@(posedge clk)
    (rst ##1 rst) |-> (prog_addr == '0 && !mem_we && !halted && !fault))
    else begin
      fail_count++;
      $error("FAIL %0t reset: prog_addr %0d mem_we %b halted %b fault %b, expected all 0",
             $time, $sampled(prog_addr), $sampled(mem_we), $sampled(halted), $sampled(fault));
    end

  first_fetch: assert property (@(posedge clk)
    $fell(rst) && !hold |-> prog_addr == prog_addr_t'(1))
    else begin
      fail_count++;
      $error("FAIL %0t prog_addr: expected 1, got %0d", $time, $sampled(prog_addr));
    end

  store_values: assert property (@(posedge clk) disable iff (rst)
    mem_we && check_slot(mem_addr) >= 0 |-> mem_wdata == expected_word(mem_addr))
    else begin
      fail_count++;
      $error("FAIL %0t mem_wdata at address %0d: expected %0d, got %0d", $time,
             $sampled(mem_addr), expected_word($sampled(mem_addr)), $sampled(mem_wdata));
    end

  no_trap_write: assert property (@(posedge clk) disable iff (rst)
    mem_we |-> mem_addr != trap_addr)
    else begin
      fail_count++;
      $error("A skipped store reached the trap address");
    end

  // Marker 1 goes before marker 2, which goes before marker 3
  marker_order: assert property (@(posedge clk) disable iff (rst)
    mem_we && (mem_addr == 8'd9 || mem_addr == 8'd10) |->
      (mem_addr == 8'd9) ? stores_seen[7] : stores_seen[8])
    else begin
      fail_count++;
      $error("Call markers were written out of order");
    end

  all_stores_before_halt: assert property (@(posedge clk) disable iff (rst)
    $rose(halted) |-> stores_seen == '1)
    else begin
      fail_count++;
      $error("The core halted before every checked store happened");
    end

  load_stall: assert property (@(posedge clk) disable iff (rst)
    $rose(is_load) && !fault |-> $stable(prog_addr) ##1 (!$stable(prog_addr) && $stable(top)))
    else begin
      fail_count++;
      $error("A load did not stall for exactly one cycle with the stack held");
    end

  halted_frozen: assert property (@(posedge clk) disable iff (rst)
    halted |=> halted && $stable(prog_addr) && !mem_we)
    else begin
      fail_count++;
      $error("The core moved after it halted");
    end

  // A drop as the first instruction after reset finds the stack empty
  fault_raised: assert property (@(posedge clk) disable iff (rst)
    $fell(rst) && prog_data == instr_t'(op_drop) |=> fault)
    else begin
      fail_count++;
      $error("A drop on an empty stack did not raise fault");
    end

  // Once faulted the core neither fetches nor stores and only reset clears fault
  fault_frozen: assert property (@(posedge clk) disable iff (rst)
    fault |-> !mem_we && $stable(prog_addr) ##1 fault)
    else begin
      fail_count++;
      $error("The core fetched, stored or left the fault state before reset");
    end

endmodule

bind stack_core stack_core_sva u_sva (
  .clk       (clk),
  .rst       (rst),
  .prog_addr (prog_addr),
  .prog_data (prog_data),
  .mem_addr  (mem_addr),
  .mem_wdata (mem_wdata),
  .mem_we    (mem_we),
  .halted    (halted),
  .fault     (fault),
  .top       (top),
  .hold      (hold)
);

// File: verif/tb_stack_core.sv
`timescale 1ns/1ps

module tb_stack_core
  import core_cfg_pkg::*;
  import core_isa_pkg::*;
();

  localparam int         clk_period    = 10;
  localparam int         drive_delay   = 1;
  localparam int         reset_cycles  = 16;
  localparam int         prog_bytes    = 77;
  localparam prog_addr_t fault_entry   = 8'h4c;
  // Each byte runs at most once and only the load stalls, so four cycles a byte is ample
  localparam int         halt_limit    = prog_bytes * 4;
  // The second run faults on its very first instruction
  localparam int         fault_limit   = reset_cycles;
  localparam int         settle_cycles = 8;

  logic       clk = 1'b0;
  logic       rst;
  prog_addr_t prog_addr;
  instr_t     prog_data;
  main_addr_t mem_raddr;
  main_addr_t mem_addr;
  word_t      mem_rdata;
  word_t      mem_wdata;
  logic       mem_we;
  logic       halted;
  logic       fault;

  instr_t prog_mem [256];
  word_t  main_mem [256];
  int     tb_errors = 0;

  always #(clk_period / 2) clk = ~clk;

  stack_core UUT (
    .clk       (clk),
    .rst       (rst),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .mem_raddr (mem_raddr),
    .mem_addr  (mem_addr),
    .mem_rdata (mem_rdata),
    .mem_wdata (mem_wdata),
    .mem_we    (mem_we),
    .halted    (halted),
    .fault     (fault)
  );

  // Program memory returns the byte for the sampled address one edge later
  always @(posedge clk) begin
    prog_data <= #drive_delay prog_mem[prog_addr];
  end

  // Main memory is synchronous on both ports
  always @(posedge clk) begin
    if (mem_we) begin
      main_mem[mem_addr] <= #drive_delay mem_wdata;
    end
    mem_rdata <= #drive_delay main_mem[mem_raddr];
  end

  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic pulse_reset();
    rst = 1'b1;
    repeat (reset_cycles) begin
      @(posedge clk);
    end
    #drive_delay;
    rst = 1'b0;
  endtask

  // Seen comes back low if the limit runs out before the flag rises
  task automatic wait_for_flag(input bit watch_fault, input int limit, output bit seen);
    int cycles;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < limit) begin
      next_cycle();
      cycles++;
      seen = watch_fault ? fault : halted;
    end
  endtask

  initial begin
    bit done;
    rst       = 1'b1;
    prog_data = '0;
    mem_rdata = '0;
    for (int i = 0; i < 256; i++) begin
      main_mem[i] = {8'(~i), 8'(i)};
    end
    $readmemh("verif/test_program.hex", prog_mem, 0, prog_bytes - 1);

    pulse_reset();
    wait_for_flag(1'b0, halt_limit, done);
    if (!done) begin
      $display("Timeout: the core never halted within %0d cycles after reset", halt_limit);
      tb_errors++;
    end else begin
      repeat (settle_cycles) begin
        next_cycle();
      end
      // The second run starts straight at the fault entry byte
      prog_mem[0] = prog_mem[fault_entry];
      pulse_reset();
      wait_for_flag(1'b1, fault_limit, done);
      if (!done) begin
        $display("Timeout: fault never rose within %0d cycles of the second run", fault_limit);
        tb_errors++;
      end else begin
        repeat (settle_cycles) begin
          next_cycle();
        end
      end
    end

    $display("Assertion failures: %0d, testbench errors: %0d", UUT.u_sva.fail_count, tb_errors);
    if (UUT.u_sva.fail_count == 0 && tb_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verif/test_program.hex
// One instruction byte per entry in program order from address 0, several entries a line
// Bytes with bit 7 set push their low 7 bits, the others are opcodes 00 nop to 0F halt
// 0x00 add, sub, and, or, xor on 9 and 5, results to addresses 1 to 5
89 85 01 81 0E
89 85 02 82 0E
89 85 03 83 0E
89 85 04 84 0E
89 85 05 85 0E
// 0x19 swap then store at 6, dup, drop and add then store at 7
83 87 08 86 0E
06 82 07 01 87 0E
// 0x24 taken jz to 0x2C over a trap store to 255
80 AC 0A
8F 80 81 02 0E
// 0x2C not-taken jz, then marker 1 at address 8
81 A7 0A 81 88 0E
// 0x32 jmp to 0x39 over a second trap store
B9 09
8F 80 81 02 0E
// 0x39 call to 0x48, then marker 3 at address 10
C8 0B 83 8A 0E
// 0x3E store 37 at 20, load it back, add 1, store at 21, halt
A5 94 0E 94 0D 81 01 95 0E 0F
// 0x48 subroutine writing marker 2 at address 9
82 89 0E 0C
// 0x4C fault entry, a drop copied to address 0 for the second run
07
